//--- all.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rat_port_if.sv
verilog/spec_rat.sv
verilog/commit_state.sv
verilog/rename_ctrl.sv
verilog/rename_top.sv
verification/tb_clkgen.sv
verification/rename_checker.sv
verification/tb_rename.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rename -f all.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rename > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

//--- verification/rename_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rename_checker (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  flush_i,
    input logic                  out_ready_i,
    input logic                  out_valid_i,
    input logic                  out_check_i,
    input logic                  src_ready1_i,
    input logic                  src_ready2_i,
    input rename_pkg::rob_id_t   out_rob_i,
    input rename_pkg::rob_id_t   src_tag1_i,
    input rename_pkg::rob_id_t   src_tag2_i,
    input rename_pkg::reg_data_t src_data1_i,
    input rename_pkg::reg_data_t src_data2_i
);
    import rename_pkg::*;

    // {check, rob, tag1, rdy1, data1, tag2, rdy2, data2}
    logic [78:0] exp_q[$];
    logic [78:0] seen;
    logic [78:0] held;
    logic        stalled;
    int          error_count;
    int          check_count;

    assign seen = {out_check_i, out_rob_i, src_tag1_i, src_ready1_i, src_data1_i,
                   src_tag2_i, src_ready2_i, src_data2_i};

    initial begin
        error_count = 0;
        check_count = 0;
        stalled     = 1'b0;
    end

    task automatic push_expected(input logic [78:0] e);
        exp_q.push_back(e);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic compare_field(input string name, input logic [31:0] e, input logic [31:0] a);
        check_count++;
        if (e !== a) begin
            error_count++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, e, a);
        end
    endtask

    task automatic compare_output(input logic [78:0] e, input logic [78:0] a);
        compare_field("out_check_o", 32'(e[78]), 32'(a[78]));
        compare_field("out_rob_o", 32'(e[77:74]), 32'(a[77:74]));
        compare_field("src_tag1_o", 32'(e[73:70]), 32'(a[73:70]));
        compare_field("src_ready1_o", 32'(e[69]), 32'(a[69]));
        compare_field("src_data1_o", e[68:37], a[68:37]);
        compare_field("src_tag2_o", 32'(e[36:33]), 32'(a[36:33]));
        compare_field("src_ready2_o", 32'(e[32]), 32'(a[32]));
        compare_field("src_data2_o", e[31:0], a[31:0]);
    endtask

    always @(posedge clk) begin
        logic [78:0] e;
        if (!rst_n_i) begin
            exp_q.delete();
            stalled = 1'b0;
        end else begin
            // output must hold while the consumer stalls
            if (stalled) begin
                check_count++;
                if (!out_valid_i) begin
                    error_count++;
                    $display("output valid dropped during a stall at %0t", $time);
                end else if (seen !== held) begin
                    compare_output(held, seen);
                end
            end
            if (out_valid_i && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("output handshake with no instruction pending at %0t", $time);
                end else begin
                    e = exp_q.pop_front();
                    compare_output(e, seen);
                end
            end
            if (flush_i) begin
                exp_q.delete();
            end
            stalled = out_valid_i && !out_ready_i && !flush_i;
            held    = seen;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_rename.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module tb_rename;
    import rename_pkg::*;

    logic clk, rst_n;
    logic flush_i, valid_i, wen_i, out_ready_i, retire_i, retire_check_i;
    arf_id_t src1_i, src2_i, dst_i, retire_dst_i;
    rob_id_t retire_rob_i;
    reg_data_t retire_data_i;
    logic ready_o, out_valid_o, out_check_o, src_ready1_o, src_ready2_o;
    rob_id_t out_rob_o, src_tag1_o, src_tag2_o;
    reg_data_t src_data1_o, src_data2_o;

    // reference model state
    logic       spec_chk [`ARF_DEPTH];
    rob_id_t    spec_rob [`ARF_DEPTH];
    logic       com_chk  [`ARF_DEPTH];
    rob_id_t    com_rob  [`ARF_DEPTH];
    reg_data_t  arf      [`ARF_DEPTH];
    // in-flight {dst, check, rob} in program order
    logic [9:0] inflight[$];
    rob_id_t    alloc_ptr;

    integer seed = 43390;
    int     tb_errors = 0;
    int     tb_checks = 0;
    int     tests_run = 0;
    logic   hung = 1'b0;
    string  hang_msg = "";

    tb_clkgen u_clkgen (.clk(clk), .rst_n_o(rst_n));

    rename_top u_rename_top (
        .clk(clk), .rst_n_i(rst_n), .flush_i(flush_i), .valid_i(valid_i), .wen_i(wen_i),
        .out_ready_i(out_ready_i), .retire_i(retire_i), .retire_check_i(retire_check_i),
        .src1_i(src1_i), .src2_i(src2_i), .dst_i(dst_i), .retire_dst_i(retire_dst_i),
        .retire_rob_i(retire_rob_i), .retire_data_i(retire_data_i), .ready_o(ready_o),
        .out_valid_o(out_valid_o), .out_check_o(out_check_o), .src_ready1_o(src_ready1_o),
        .src_ready2_o(src_ready2_o), .out_rob_o(out_rob_o), .src_tag1_o(src_tag1_o),
        .src_tag2_o(src_tag2_o), .src_data1_o(src_data1_o), .src_data2_o(src_data2_o)
    );

    rename_checker u_checker (
        .clk(clk), .rst_n_i(rst_n), .flush_i(flush_i), .out_ready_i(out_ready_i),
        .out_valid_i(out_valid_o), .out_check_i(out_check_o), .src_ready1_i(src_ready1_o),
        .src_ready2_i(src_ready2_o), .out_rob_i(out_rob_o), .src_tag1_i(src_tag1_o),
        .src_tag2_i(src_tag2_o), .src_data1_i(src_data1_o), .src_data2_i(src_data2_o)
    );

    function automatic int total_errors();
        return tb_errors + u_checker.error_count;
    endfunction

    // spec equal to commit means the value sits in the arf
    function automatic logic [78:0] expected_output(input arf_id_t s1, input arf_id_t s2,
                                                    input arf_id_t d);
        logic      r1, r2;
        reg_data_t d1, d2;
        r1 = (s1 == 5'd0) || (spec_chk[s1] == com_chk[s1] && spec_rob[s1] == com_rob[s1]);
        r2 = (s2 == 5'd0) || (spec_chk[s2] == com_chk[s2] && spec_rob[s2] == com_rob[s2]);
        d1 = r1 ? arf[s1] : 32'd0;
        d2 = r2 ? arf[s2] : 32'd0;
        return {~com_chk[d], alloc_ptr, spec_rob[s1], r1, d1, spec_rob[s2], r2, d2};
    endfunction

    task automatic clear_tables();
        for (int i = 0; i < `ARF_DEPTH; i++) begin
            spec_chk[i] = 1'b0;
            spec_rob[i] = '0;
            com_chk[i]  = 1'b0;
            com_rob[i]  = '0;
        end
        inflight.delete();
        alloc_ptr = '0;
    endtask

    task automatic check_bit(input string name, input logic e, input logic a);
        tb_checks++;
        if (e !== a) begin
            tb_errors++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, e, a);
        end
    endtask

    // one cycle of stimulus and the matching model update
    task automatic drive_cycle(input logic v, input arf_id_t s1, input arf_id_t s2,
                               input arf_id_t d, input logic w, input logic ordy,
                               input logic ret, input logic fl, output logic acc);
        logic [9:0]  rec;
        logic [78:0] e;
        logic        ret_now;
        logic        exp_ready;
        int          in_use;
        reg_data_t   rdata;
        @(negedge clk);
        in_use  = inflight.size();
        ret_now = ret && !fl && (in_use > 0);
        rdata   = reg_data_t'($random(seed));
        rec     = ret_now ? inflight.pop_front() : 10'd0;
        valid_i        = v;
        src1_i         = s1;
        src2_i         = s2;
        dst_i          = d;
        wen_i          = w;
        out_ready_i    = ordy;
        flush_i        = fl;
        retire_i       = ret_now;
        retire_dst_i   = rec[9:5];
        retire_check_i = rec[4];
        retire_rob_i   = rec[3:0];
        retire_data_i  = rdata;
        #1;
        // occupancy counts what was in flight before this edge
        exp_ready = !fl && (in_use < `ROB_DEPTH) &&
                    (u_checker.pending_count() == 0 || ordy);
        check_bit("out_valid_o", u_checker.pending_count() != 0, out_valid_o);
        check_bit("ready_o", exp_ready, ready_o);
        acc = v && exp_ready;
        // retire lands before the lookup of the same cycle
        if (ret_now && rec[9:5] != 5'd0) begin
            com_chk[rec[9:5]] = rec[4];
            com_rob[rec[9:5]] = rec[3:0];
            arf[rec[9:5]]     = rdata;
        end
        if (fl) begin
            clear_tables();
        end
        if (acc) begin
            e = expected_output(s1, s2, d);
            u_checker.push_expected(e);
            if (w && d != 5'd0) begin
                spec_chk[d] = e[78];
                spec_rob[d] = alloc_ptr;
            end
            inflight.push_back({(w ? d : 5'd0), e[78], alloc_ptr});
            alloc_ptr = alloc_ptr + 4'd1;
        end
    endtask

    task automatic issue(input arf_id_t s1, input arf_id_t s2, input arf_id_t d);
        logic acc;
        int   n;
        acc = 1'b0;
        n   = 0;
        while (!acc && !hung) begin
            drive_cycle(1'b1, s1, s2, d, 1'b1, 1'b1, 1'b0, 1'b0, acc);
            n++;
            if (!acc && n >= 40) begin
                hung     = 1'b1;
                hang_msg = "an instruction was never accepted";
            end
        end
    endtask

    task automatic retire_all();
        logic acc;
        int   n;
        n = 0;
        while (inflight.size() > 0 && !hung) begin
            drive_cycle(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b1, 1'b0, acc);
            n++;
            if (n >= 40) begin
                hung     = 1'b1;
                hang_msg = "in-flight instructions never retired";
            end
        end
    endtask

    task automatic drain_outputs();
        logic acc;
        int   n;
        n = 0;
        while (u_checker.pending_count() > 0 && !hung) begin
            drive_cycle(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0, acc);
            n++;
            if (n >= 40) begin
                hung     = 1'b1;
                hang_msg = "expected outputs never appeared";
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        $display("test %0d %s finished, %0d errors", tests_run, name,
                 total_errors() - errs_before);
    endtask

    initial begin
        logic acc;
        int   n;
        int   e0;
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        wen_i          = 1'b0;
        out_ready_i    = 1'b0;
        retire_i       = 1'b0;
        retire_check_i = 1'b0;
        src1_i         = '0;
        src2_i         = '0;
        dst_i          = '0;
        retire_dst_i   = '0;
        retire_rob_i   = '0;
        retire_data_i  = '0;
        clear_tables();
        for (int i = 0; i < `ARF_DEPTH; i++) begin
            arf[i] = '0;
        end

        n = 0;
        while (rst_n !== 1'b1 && !hung) begin
            @(negedge clk);
            n++;
            if (n >= 20) begin
                hung     = 1'b1;
                hang_msg = "reset never released";
            end
        end

        e0 = total_errors();
        @(negedge clk);
        #1;
        check_bit("out_valid_o", 1'b0, out_valid_o);
        check_bit("ready_o", 1'b1, ready_o);
        issue(5'd1, 5'd2, 5'd3);
        issue(5'd4, 5'd5, 5'd6);
        issue(5'd0, 5'd7, 5'd8);
        end_test("reset and first ids", e0);

        e0 = total_errors();
        issue(5'd3, 5'd0, 5'd9);
        issue(5'd9, 5'd6, 5'd10);
        end_test("dependency", e0);

        e0 = total_errors();
        retire_all();
        issue(5'd0, 5'd0, 5'd11);
        drive_cycle(1'b1, 5'd11, 5'd3, 5'd12, 1'b1, 1'b1, 1'b1, 1'b0, acc);
        check_bit("ready_o", 1'b1, ready_o);
        retire_all();
        issue(5'd3, 5'd11, 5'd13);
        end_test("retirement", e0);

        e0 = total_errors();
        drive_cycle(1'b1, 5'd1, 5'd2, 5'd14, 1'b1, 1'b0, 1'b0, 1'b0, acc);
        repeat (3) begin
            drive_cycle(1'b1, 5'd14, 5'd2, 5'd15, 1'b1, 1'b0, 1'b0, 1'b0, acc);
            check_bit("ready_o", 1'b0, ready_o);
        end
        drain_outputs();
        retire_all();
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            issue(arf_id_t'($random(seed)), arf_id_t'($random(seed)), arf_id_t'(i + 16));
        end
        drive_cycle(1'b1, 5'd16, 5'd17, 5'd18, 1'b1, 1'b1, 1'b0, 1'b0, acc);
        check_bit("ready_o", 1'b0, ready_o);
        drive_cycle(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b1, 1'b0, acc);
        drive_cycle(1'b1, 5'd16, 5'd31, 5'd19, 1'b1, 1'b1, 1'b0, 1'b0, acc);
        check_bit("ready_o", 1'b1, ready_o);
        retire_all();
        end_test("back-pressure", e0);

        e0 = total_errors();
        issue(5'd3, 5'd4, 5'd20);
        drive_cycle(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b0, 1'b1, acc);
        issue(5'd3, 5'd11, 5'd1);
        issue(5'd20, 5'd1, 5'd2);
        end_test("flush", e0);

        // random mix with an occasional flush
        e0 = total_errors();
        for (int i = 0; i < 300 && !hung; i++) begin
            drive_cycle(1'($random(seed)), arf_id_t'($random(seed)), arf_id_t'($random(seed)),
                        arf_id_t'($random(seed)), 1'($random(seed)),
                        ($random(seed) & 3) != 0, 1'($random(seed)),
                        ($random(seed) & 63) == 0, acc);
        end
        drain_outputs();
        retire_all();
        end_test("random traffic", e0);

        $display("tests %0d, checks %0d, errors %0d", tests_run,
                 tb_checks + u_checker.check_count, total_errors());
        if (hung) begin
            $display("run stopped: %s", hang_msg);
        end
        if (hung || total_errors() != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/commit_state.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module commit_state (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,
    rat_port_if.tbl bus
);
    import rename_pkg::*;

    logic      check_q [`ARF_DEPTH];
    rob_id_t   rob_q   [`ARF_DEPTH];
    reg_data_t arf_q   [`ARF_DEPTH];
    logic      wr_en;
    logic      hit1;
    logic      hit2;
    logic      hit3;

    assign wr_en = bus.we && (bus.waddr != '0);

    // committed alias entries
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < `ARF_DEPTH; i++) begin
                check_q[i] <= 1'b0;
                rob_q[i]   <= '0;
            end
        end else if (wr_en) begin
            check_q[bus.waddr] <= bus.wcheck;
            rob_q[bus.waddr]   <= bus.wrob;
        end
    end

    // architectural values survive a flush
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ARF_DEPTH; i++) begin
                arf_q[i] <= '0;
            end
        end else if (wr_en) begin
            arf_q[bus.waddr] <= bus.wdata;
        end
    end

    // same-cycle retire bypass, wr_en already excludes r0
    assign hit1 = wr_en && (bus.raddr1 == bus.waddr);
    assign hit2 = wr_en && (bus.raddr2 == bus.waddr);
    assign hit3 = wr_en && (bus.raddr3 == bus.waddr);

    assign bus.rcheck1 = hit1 ? bus.wcheck : check_q[bus.raddr1];
    assign bus.rrob1   = hit1 ? bus.wrob   : rob_q[bus.raddr1];
    assign bus.rdata1  = hit1 ? bus.wdata  : arf_q[bus.raddr1];

    assign bus.rcheck2 = hit2 ? bus.wcheck : check_q[bus.raddr2];
    assign bus.rrob2   = hit2 ? bus.wrob   : rob_q[bus.raddr2];
    assign bus.rdata2  = hit2 ? bus.wdata  : arf_q[bus.raddr2];

    assign bus.rcheck3 = hit3 ? bus.wcheck : check_q[bus.raddr3];

endmodule

`default_nettype wire

//--- verilog/rat_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface rat_port_if;
    import rename_pkg::*;

    // source lookups
    arf_id_t   raddr1;
    arf_id_t   raddr2;
    logic      rcheck1;
    logic      rcheck2;
    rob_id_t   rrob1;
    rob_id_t   rrob2;
    reg_data_t rdata1;
    reg_data_t rdata2;

    // destination lookup, only served by the commit table
    arf_id_t   raddr3;
    logic      rcheck3;

    // update side
    logic      we;
    arf_id_t   waddr;
    logic      wcheck;
    rob_id_t   wrob;
    reg_data_t wdata;

    modport tbl (
        input  raddr1, raddr2, raddr3, we, waddr, wcheck, wrob, wdata,
        output rcheck1, rcheck2, rcheck3, rrob1, rrob2, rdata1, rdata2
    );

    modport user (
        output raddr1, raddr2, raddr3, we, waddr, wcheck, wrob, wdata,
        input  rcheck1, rcheck2, rcheck3, rrob1, rrob2, rdata1, rdata2
    );

endinterface

`default_nettype wire

//--- verilog/rename_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module rename_ctrl (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                valid_i,
    input  logic                out_ready_i,
    input  logic                retire_i,
    input  rename_pkg::arf_id_t src1_i,
    input  rename_pkg::arf_id_t src2_i,
    input  rename_pkg::arf_id_t dst_i,
    input  logic                wen_i,
    output logic                ready_o,
    output logic                out_valid_o,
    output logic                out_check_o,
    output logic                src_ready1_o,
    output logic                src_ready2_o,
    output rename_pkg::rob_id_t   out_rob_o,
    output rename_pkg::rob_id_t   src_tag1_o,
    output rename_pkg::rob_id_t   src_tag2_o,
    output rename_pkg::reg_data_t src_data1_o,
    output rename_pkg::reg_data_t src_data2_o,
    rat_port_if.user            spec,
    rat_port_if.user            commit
);
    import rename_pkg::*;

    rob_id_t   alloc_ptr_q;
    rob_cnt_t  occ_q;
    logic      rob_free;
    logic      out_free;
    logic      accept;
    logic      new_check;
    logic      hit1;
    logic      hit2;

    logic      out_valid_q;
    logic      out_check_q;
    rob_id_t   out_rob_q;
    rob_id_t   src_tag1_q;
    rob_id_t   src_tag2_q;
    logic      src_ready1_q;
    logic      src_ready2_q;
    reg_data_t src_data1_q;
    reg_data_t src_data2_q;

    assign rob_free = occ_q < rob_cnt_t'(`ROB_DEPTH);
    assign out_free = !out_valid_q || out_ready_i;
    assign ready_o  = !flush_i && rob_free && out_free;
    assign accept   = valid_i && ready_o;

    // lookups
    assign spec.raddr1   = src1_i;
    assign spec.raddr2   = src2_i;
    assign commit.raddr1 = src1_i;
    assign commit.raddr2 = src2_i;
    assign commit.raddr3 = dst_i;

    // flipping the committed check keeps a fresh mapping distinct from it
    assign new_check   = ~commit.rcheck3;
    assign spec.we     = accept && wen_i && (dst_i != '0);
    assign spec.waddr  = dst_i;
    assign spec.wcheck = new_check;
    assign spec.wrob   = alloc_ptr_q;

    // spec equal to commit means the value is already in the arf
    assign hit1 = (src1_i == '0) ||
                  ((spec.rcheck1 == commit.rcheck1) && (spec.rrob1 == commit.rrob1));
    assign hit2 = (src2_i == '0) ||
                  ((spec.rcheck2 == commit.rcheck2) && (spec.rrob2 == commit.rrob2));

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            alloc_ptr_q <= '0;
            occ_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            alloc_ptr_q <= alloc_ptr_q + rob_id_t'(accept);
            occ_q       <= occ_q + rob_cnt_t'(accept) - rob_cnt_t'(retire_i);
            if (accept) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_check_q  <= new_check;
            out_rob_q    <= alloc_ptr_q;
            src_tag1_q   <= spec.rrob1;
            src_tag2_q   <= spec.rrob2;
            src_ready1_q <= hit1;
            src_ready2_q <= hit2;
            src_data1_q  <= hit1 ? commit.rdata1 : '0;
            src_data2_q  <= hit2 ? commit.rdata2 : '0;
        end
    end

    assign out_valid_o  = out_valid_q;
    assign out_check_o  = out_check_q;
    assign out_rob_o    = out_rob_q;
    assign src_tag1_o   = src_tag1_q;
    assign src_tag2_o   = src_tag2_q;
    assign src_ready1_o = src_ready1_q;
    assign src_ready2_o = src_ready2_q;
    assign src_data1_o  = src_data1_q;
    assign src_data2_o  = src_data2_q;

endmodule

`default_nettype wire

//--- verilog/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file
`define ARF_DEPTH 32
`define ARF_ID_W  5

// reorder buffer, ids double as physical tags
`define ROB_DEPTH 16
`define ROB_ID_W  4

// register payload
`define DATA_W    32

`endif

//--- verilog/rename_pkg.sv
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    // architectural register id
    typedef logic [`ARF_ID_W-1:0] arf_id_t;

    // rob id, also the tag a consumer waits on
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // register value
    typedef logic [`DATA_W-1:0] reg_data_t;

    // occupancy 0..ROB_DEPTH, one bit wider than the id
    typedef logic [`ROB_ID_W:0] rob_cnt_t;

endpackage

`default_nettype wire

//--- verilog/rename_top.sv
`timescale 1ns/1ns
`default_nettype none

module rename_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  valid_i,
    input  logic                  wen_i,
    input  logic                  out_ready_i,
    input  logic                  retire_i,
    input  logic                  retire_check_i,
    input  rename_pkg::arf_id_t   src1_i,
    input  rename_pkg::arf_id_t   src2_i,
    input  rename_pkg::arf_id_t   dst_i,
    input  rename_pkg::arf_id_t   retire_dst_i,
    input  rename_pkg::rob_id_t   retire_rob_i,
    input  rename_pkg::reg_data_t retire_data_i,
    output logic                  ready_o,
    output logic                  out_valid_o,
    output logic                  out_check_o,
    output logic                  src_ready1_o,
    output logic                  src_ready2_o,
    output rename_pkg::rob_id_t   out_rob_o,
    output rename_pkg::rob_id_t   src_tag1_o,
    output rename_pkg::rob_id_t   src_tag2_o,
    output rename_pkg::reg_data_t src_data1_o,
    output rename_pkg::reg_data_t src_data2_o
);

    rat_port_if spec_bus ();
    rat_port_if commit_bus ();

    // retire drives the commit side directly
    assign commit_bus.we     = retire_i;
    assign commit_bus.waddr  = retire_dst_i;
    assign commit_bus.wcheck = retire_check_i;
    assign commit_bus.wrob   = retire_rob_i;
    assign commit_bus.wdata  = retire_data_i;

    spec_rat u_spec_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .bus     (spec_bus)
    );

    commit_state u_commit_state (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .bus     (commit_bus)
    );

    rename_ctrl u_rename_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .out_ready_i  (out_ready_i),
        .retire_i     (retire_i),
        .src1_i       (src1_i),
        .src2_i       (src2_i),
        .dst_i        (dst_i),
        .wen_i        (wen_i),
        .ready_o      (ready_o),
        .out_valid_o  (out_valid_o),
        .out_check_o  (out_check_o),
        .src_ready1_o (src_ready1_o),
        .src_ready2_o (src_ready2_o),
        .out_rob_o    (out_rob_o),
        .src_tag1_o   (src_tag1_o),
        .src_tag2_o   (src_tag2_o),
        .src_data1_o  (src_data1_o),
        .src_data2_o  (src_data2_o),
        .spec         (spec_bus),
        .commit       (commit_bus)
    );

endmodule

`default_nettype wire

//--- verilog/spec_rat.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_defines.svh"

module spec_rat (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,
    rat_port_if.tbl bus
);
    import rename_pkg::*;

    logic    check_q [`ARF_DEPTH];
    rob_id_t rob_q   [`ARF_DEPTH];
    logic    wr_en;

    // r0 has no producer
    assign wr_en = bus.we && (bus.waddr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < `ARF_DEPTH; i++) begin
                check_q[i] <= 1'b0;
                rob_q[i]   <= '0;
            end
        end else if (wr_en) begin
            check_q[bus.waddr] <= bus.wcheck;
            rob_q[bus.waddr]   <= bus.wrob;
        end
    end

    // no bypass here, an instruction must not see its own mapping
    assign bus.rcheck1 = check_q[bus.raddr1];
    assign bus.rrob1   = rob_q[bus.raddr1];
    assign bus.rcheck2 = check_q[bus.raddr2];
    assign bus.rrob2   = rob_q[bus.raddr2];

endmodule

`default_nettype wire
